//--- common/mem_pkg.sv
package mem_pkg;

	// memory operation carried by the execute bundle.
	typedef enum logic [3:0] {
		MEM_X = 4'd0,
		LB    = 4'd1,
		LH    = 4'd2,
		LW    = 4'd3,
		LBU   = 4'd4,
		LHU   = 4'd5,
		SB    = 4'd6,
		SH    = 4'd7,
		SW    = 4'd8
	} mem_op_e;

	typedef enum logic [1:0] {
		CMD_NONE  = 2'd0,
		CMD_READ  = 2'd1,
		CMD_WRITE = 2'd2
	} mem_cmd_e;

	typedef struct packed {
		logic [31:0] reg_pc;
		logic [31:0] alu_out;  // byte address for loads and stores.
		logic [31:0] rs2_data;
		mem_op_e     op;
		logic [3:0]  wb_sel;
	} ex_to_mem_t;

	typedef struct packed {
		logic [31:0] read_data;
		logic [31:0] reg_pc;
		logic [31:0] alu_out;
		logic [3:0]  wb_sel;
	} mem_to_wb_t;

	// wdata and wmask are right-aligned, the ram shifts them into lane.
	typedef struct packed {
		mem_cmd_e    cmd;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] wmask;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        valid;
	} mem_rsp_t;

	function automatic logic is_store_op(input mem_op_e op);
		case (op)
			SB, SH, SW: is_store_op = 1'b1;
			default:    is_store_op = 1'b0;
		endcase
	endfunction

endpackage

//--- source/data_ram.sv
`timescale 1ns/100ps

module data_ram #(
	parameter int DEPTH_WORDS  = 256,
	parameter int READ_LATENCY = 2
) (
	input  logic              clk,
	input  logic              rst,
	input  mem_pkg::mem_req_t req,
	output mem_pkg::mem_rsp_t rsp
);
	import mem_pkg::*;

	localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;

	logic [31:0]             mem [DEPTH_WORDS];
	logic [IDX_W-1:0]        idx;
	logic [4:0]              shamt;
	logic [31:0]             lane_data;
	logic [31:0]             lane_mask;
	logic [READ_LATENCY-1:0] valid_pipe;
	logic [31:0]             data_pipe [READ_LATENCY];

	// word index wraps modulo the depth.
	assign idx = IDX_W'(req.addr[31:2] % DEPTH_WORDS);

	assign shamt     = {req.addr[1:0], 3'b000};
	assign lane_data = req.wdata << shamt;
	assign lane_mask = req.wmask << shamt;

	always_ff @(posedge clk) begin
		if (req.cmd == CMD_WRITE)
			mem[idx] <= (mem[idx] & ~lane_mask) | (lane_data & lane_mask);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe[0] <= (req.cmd == CMD_READ);
			for (int i = 1; i < READ_LATENCY; i++)
				valid_pipe[i] <= valid_pipe[i-1];
		end
	end

	// first stage samples the word at the accepting edge.
	always_ff @(posedge clk) begin
		data_pipe[0] <= mem[idx] >> shamt;
		for (int i = 1; i < READ_LATENCY; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	assign rsp = '{rdata: data_pipe[READ_LATENCY-1], valid: valid_pipe[READ_LATENCY-1]};

endmodule

//--- source/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
	input  logic              clk,
	input  logic              rst,
	output logic              d_ready,
	input  mem_pkg::mem_req_t d_req,
	output mem_pkg::mem_rsp_t d_rsp,
	output logic              i_ready,
	input  mem_pkg::mem_req_t i_req,
	output mem_pkg::mem_rsp_t i_rsp,
	output mem_pkg::mem_req_t ram_req,
	input  mem_pkg::mem_rsp_t ram_rsp
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		ARB_OFFER     = 2'd0,
		ARB_ACCEPT    = 2'd1,
		ARB_BUSY_READ = 2'd2
	} arb_state_e;

	localparam logic PORT_D = 1'b0;
	localparam logic PORT_I = 1'b1;

	arb_state_e state;
	logic       rr_ptr;  // port offered in the current round.
	logic       owner;   // port waiting on read data.
	mem_req_t   sel_req;

	assign d_ready = (state == ARB_OFFER) && (rr_ptr == PORT_D);
	assign i_ready = (state == ARB_OFFER) && (rr_ptr == PORT_I);

	assign sel_req = (rr_ptr == PORT_I) ? i_req : d_req;

	// only the offered port reaches the ram, and only in the accept cycle.
	always_comb begin
		ram_req = sel_req;
		if (state != ARB_ACCEPT)
			ram_req.cmd = CMD_NONE;
	end

	always_comb begin
		d_rsp.rdata = ram_rsp.rdata;
		i_rsp.rdata = ram_rsp.rdata;
		d_rsp.valid = ram_rsp.valid && (state == ARB_BUSY_READ) && (owner == PORT_D);
		i_rsp.valid = ram_rsp.valid && (state == ARB_BUSY_READ) && (owner == PORT_I);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= ARB_OFFER;
			rr_ptr <= PORT_D;  // data side gets the first offer.
			owner  <= PORT_D;
		end else begin
			case (state)
				ARB_OFFER: begin
					state <= ARB_ACCEPT;
				end
				ARB_ACCEPT: begin
					// next offer goes to the other port whatever happened.
					rr_ptr <= ~rr_ptr;
					owner  <= rr_ptr;
					if (sel_req.cmd == CMD_READ)
						state <= ARB_BUSY_READ;
					else
						state <= ARB_OFFER;
				end
				ARB_BUSY_READ: begin
					if (ram_rsp.valid)
						state <= ARB_OFFER;
				end
				default: begin
					state <= ARB_OFFER;
				end
			endcase
		end
	end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              fetch_start,
	input  logic [31:0]       fetch_pc,
	output logic [31:0]       instr,
	output logic              instr_valid,
	output logic              fetch_busy,
	input  logic              cmd_ready,
	output mem_pkg::mem_req_t req,
	input  mem_pkg::mem_rsp_t rsp
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		F_IDLE       = 2'd0,
		F_WAIT_READY = 2'd1,
		F_WAIT_DATA  = 2'd2
	} fetch_state_e;

	fetch_state_e state;
	logic [31:0]  pc;
	mem_cmd_e     cmd_q;

	assign fetch_busy = (state != F_IDLE);

	// instruction reads are always whole aligned words.
	assign req = '{cmd: cmd_q, addr: {pc[31:2], 2'b00}, wdata: '0, wmask: '0};

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= F_IDLE;
			cmd_q       <= CMD_NONE;
			instr_valid <= 1'b0;
		end else begin
			cmd_q       <= CMD_NONE;
			instr_valid <= 1'b0;
			case (state)
				F_IDLE: begin
					if (fetch_start)
						state <= F_WAIT_READY;
				end
				F_WAIT_READY: begin
					if (cmd_ready) begin
						cmd_q <= CMD_READ;
						state <= F_WAIT_DATA;
					end
				end
				F_WAIT_DATA: begin
					if (rsp.valid) begin
						instr_valid <= 1'b1;
						state       <= F_IDLE;  // free again in the valid cycle.
					end
				end
				default: begin
					state <= F_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == F_IDLE && fetch_start)
			pc <= fetch_pc;
		if (state == F_WAIT_DATA && rsp.valid)
			instr <= rsp.rdata;
	end

endmodule

//--- memory_stage/memory_stage.sv
`timescale 1ns/100ps

module memory_stage (
	input  logic                clk,
	input  logic                rst,
	input  mem_pkg::ex_to_mem_t ex_in,
	output logic                next_flg,
	output mem_pkg::mem_to_wb_t wb_out,
	input  logic                cmd_ready,
	output mem_pkg::mem_req_t   req,
	input  mem_pkg::mem_rsp_t   rsp
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		ST_WAIT            = 2'd0,
		ST_WAIT_READY      = 2'd1,
		ST_WAIT_READ_VALID = 2'd2,
		ST_END             = 2'd3
	} state_e;

	state_e      state;
	ex_to_mem_t  saved;
	logic [31:0] load_data;
	mem_cmd_e    cmd_q;
	logic [31:0] addr_q;
	logic [31:0] wdata_q;
	logic [31:0] wmask_q;

	function automatic logic [31:0] store_mask(input mem_op_e op);
		case (op)
			SB:      store_mask = 32'h0000_00ff;
			SH:      store_mask = 32'h0000_ffff;
			SW:      store_mask = 32'hffff_ffff;
			default: store_mask = 32'h0000_0000;  // reads carry no mask.
		endcase
	endfunction

	// rdata arrives right-aligned, so only the low lanes matter.
	function automatic logic [31:0] extend_load(input mem_op_e op, input logic [31:0] rdata);
		case (op)
			LB:      extend_load = {{24{rdata[7]}}, rdata[7:0]};
			LBU:     extend_load = {24'h00_0000, rdata[7:0]};
			LH:      extend_load = {{16{rdata[15]}}, rdata[15:0]};
			LHU:     extend_load = {16'h0000, rdata[15:0]};
			default: extend_load = rdata;
		endcase
	endfunction

	// stage may advance on a bypassed alu op or once the access is done.
	assign next_flg = (state == ST_WAIT && ex_in.op == MEM_X) || (state == ST_END);

	assign req = '{cmd: cmd_q, addr: addr_q, wdata: wdata_q, wmask: wmask_q};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_WAIT;
			cmd_q <= CMD_NONE;
		end else begin
			cmd_q <= CMD_NONE;  // command is a single-cycle strobe.
			case (state)
				ST_WAIT: begin
					if (ex_in.op != MEM_X)
						state <= ST_WAIT_READY;
				end
				ST_WAIT_READY: begin
					if (cmd_ready) begin
						if (is_store_op(saved.op)) begin
							cmd_q <= CMD_WRITE;
							state <= ST_END;  // write is done once accepted.
						end else begin
							cmd_q <= CMD_READ;
							state <= ST_WAIT_READ_VALID;
						end
					end
				end
				ST_WAIT_READ_VALID: begin
					if (rsp.valid)
						state <= ST_END;
				end
				ST_END: begin
					state <= ST_WAIT;
				end
				default: begin
					state <= ST_WAIT;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			ST_WAIT: begin
				if (ex_in.op != MEM_X) begin
					saved     <= ex_in;
					load_data <= '1;  // stores report all ones.
				end else begin
					wb_out <= '{
						read_data: 32'hffff_ffff,
						reg_pc:    ex_in.reg_pc,
						alu_out:   ex_in.alu_out,
						wb_sel:    ex_in.wb_sel
					};
				end
			end
			ST_WAIT_READY: begin
				if (cmd_ready) begin
					addr_q  <= saved.alu_out;
					wdata_q <= saved.rs2_data;
					wmask_q <= store_mask(saved.op);
				end
			end
			ST_WAIT_READ_VALID: begin
				if (rsp.valid)
					load_data <= extend_load(saved.op, rsp.rdata);
			end
			ST_END: begin
				wb_out <= '{
					read_data: load_data,
					reg_pc:    saved.reg_pc,
					alu_out:   saved.alu_out,
					wb_sel:    saved.wb_sel
				};
			end
			default: begin
			end
		endcase
	end

endmodule

//--- source/mem_subsystem.sv
`timescale 1ns/100ps

module mem_subsystem #(
	parameter int DEPTH_WORDS  = 256,
	parameter int READ_LATENCY = 2
) (
	input  logic                clk,
	input  logic                rst,
	input  mem_pkg::ex_to_mem_t ex_in,
	output logic                next_flg,
	output mem_pkg::mem_to_wb_t wb_out,
	input  logic                fetch_start,
	input  logic [31:0]         fetch_pc,
	output logic [31:0]         instr,
	output logic                instr_valid,
	output logic                fetch_busy
);
	import mem_pkg::*;

	logic     d_ready;
	mem_req_t d_req;
	mem_rsp_t d_rsp;
	logic     i_ready;
	mem_req_t i_req;
	mem_rsp_t i_rsp;
	mem_req_t ram_req;
	mem_rsp_t ram_rsp;

	memory_stage u_memory_stage (
		.clk       (clk),
		.rst       (rst),
		.ex_in     (ex_in),
		.next_flg  (next_flg),
		.wb_out    (wb_out),
		.cmd_ready (d_ready),
		.req       (d_req),
		.rsp       (d_rsp)
	);

	fetch_unit u_fetch_unit (
		.clk         (clk),
		.rst         (rst),
		.fetch_start (fetch_start),
		.fetch_pc    (fetch_pc),
		.instr       (instr),
		.instr_valid (instr_valid),
		.fetch_busy  (fetch_busy),
		.cmd_ready   (i_ready),
		.req         (i_req),
		.rsp         (i_rsp)
	);

	mem_arbiter u_mem_arbiter (
		.clk     (clk),
		.rst     (rst),
		.d_ready (d_ready),
		.d_req   (d_req),
		.d_rsp   (d_rsp),
		.i_ready (i_ready),
		.i_req   (i_req),
		.i_rsp   (i_rsp),
		.ram_req (ram_req),
		.ram_rsp (ram_rsp)
	);

	data_ram #(
		.DEPTH_WORDS  (DEPTH_WORDS),
		.READ_LATENCY (READ_LATENCY)
	) u_data_ram (
		.clk (clk),
		.rst (rst),
		.req (ram_req),
		.rsp (ram_rsp)
	);

endmodule

//--- bench/mem_subsystem_asserts.sv
`timescale 1ns/100ps

module mem_subsystem_asserts (
	input logic              clk,
	input logic              rst,
	input logic              d_ready,
	input logic              i_ready,
	input mem_pkg::mem_req_t d_req,
	input mem_pkg::mem_req_t i_req,
	input mem_pkg::mem_rsp_t d_rsp,
	input mem_pkg::mem_rsp_t i_rsp,
	input mem_pkg::mem_req_t ram_req,
	input mem_pkg::mem_rsp_t ram_rsp
);
	import mem_pkg::*;

	int   fail_count = 0;
	logic read_open;  // a read was sent to the ram and has not returned.

	always_ff @(posedge clk) begin
		if (rst)
			read_open <= 1'b0;
		else if (ram_req.cmd == CMD_READ)
			read_open <= 1'b1;
		else if (ram_rsp.valid)
			read_open <= 1'b0;
	end

	cmd_after_offer: assert property (@(posedge clk) disable iff (rst)
		ram_req.cmd != CMD_NONE |-> $past(d_ready || i_ready))
	else begin
		fail_count++;
		$error("ram command without a ready offer in the previous cycle");
	end

	// an offer goes to one port and lasts a single cycle.
	single_offer: assert property (@(posedge clk) disable iff (rst)
		(d_ready || i_ready) |-> !(d_ready && i_ready) ##1 !(d_ready || i_ready))
	else begin
		fail_count++;
		$error("ready offered to both ports at once or held for more than one cycle");
	end

	valid_only_in_read: assert property (@(posedge clk) disable iff (rst)
		(ram_rsp.valid || d_rsp.valid || i_rsp.valid) |-> read_open)
	else begin
		fail_count++;
		$error("read valid seen with no read outstanding");
	end

	idle_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> (d_req.cmd == CMD_NONE && i_req.cmd == CMD_NONE
			&& ram_req.cmd == CMD_NONE))
	else begin
		fail_count++;
		$error("command active in the cycle after reset");
	end

endmodule

bind mem_arbiter mem_subsystem_asserts u_arb_asserts (
	.clk     (clk),
	.rst     (rst),
	.d_ready (d_ready),
	.i_ready (i_ready),
	.d_req   (d_req),
	.i_req   (i_req),
	.d_rsp   (d_rsp),
	.i_rsp   (i_rsp),
	.ram_req (ram_req),
	.ram_rsp (ram_rsp)
);

//--- bench/mem_subsystem_tb.sv
`timescale 1ns/100ps

module mem_subsystem_tb;
	import mem_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int NUM_TESTS   = 6;
	localparam int TEST_CYCLES = 200;
	localparam int RAM_BYTES   = 1024;  // 256 words at the default depth.

	logic        clk;
	logic        rst;
	ex_to_mem_t  ex_in;
	logic        next_flg;
	mem_to_wb_t  wb_out;
	logic        fetch_start;
	logic [31:0] fetch_pc;
	logic [31:0] instr;
	logic        instr_valid;
	logic        fetch_busy;

	logic [7:0]  ref_mem [RAM_BYTES];  // byte-wide little-endian model.
	logic [31:0] lfsr;

	mem_subsystem DUT (
		.clk         (clk),
		.rst         (rst),
		.ex_in       (ex_in),
		.next_flg    (next_flg),
		.wb_out      (wb_out),
		.fetch_start (fetch_start),
		.fetch_pc    (fetch_pc),
		.instr       (instr),
		.instr_valid (instr_valid),
		.fetch_busy  (fetch_busy)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_wb(input mem_to_wb_t got, input mem_to_wb_t exp, input string what);
		if (got !== exp)
			fail_now($sformatf("ERR %0t: %s got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_instr(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			fail_now($sformatf("ERR %0t: %s got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_now($sformatf("ERR %0t: %s got %b, expected %b", $time, what, got, exp));
	endtask

	// x^32 + x^22 + x^2 + x + 1, one step per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic int op_bytes(input mem_op_e op);
		case (op)
			LB, LBU, SB: return 1;
			LH, LHU, SH: return 2;
			default:     return 4;
		endcase
	endfunction

	task automatic model_store(input logic [31:0] addr, input logic [31:0] data, input mem_op_e op);
		for (int i = 0; i < op_bytes(op); i++)
			ref_mem[(addr + i) % RAM_BYTES] = data[8*i +: 8];
	endtask

	function automatic logic [31:0] model_load(input logic [31:0] addr, input mem_op_e op);
		logic [31:0] raw;
		raw = '0;
		for (int i = 0; i < op_bytes(op); i++)
			raw[8*i +: 8] = ref_mem[(addr + i) % RAM_BYTES];
		case (op)
			LB:      return {{24{raw[7]}}, raw[7:0]};
			LH:      return {{16{raw[15]}}, raw[15:0]};
			default: return raw;
		endcase
	endfunction

	function automatic ex_to_mem_t make_bundle(input mem_op_e op, input logic [31:0] addr,
			input logic [31:0] data);
		ex_to_mem_t b;
		b.reg_pc   = rand_bits(30) << 2;
		b.alu_out  = addr;
		b.rs2_data = data;
		b.op       = op;
		b.wb_sel   = 4'(rand_bits(4));
		return b;
	endfunction

	// one bundle through the stage, held until next_flg marks the end.
	task automatic run_access(input ex_to_mem_t b);
		mem_to_wb_t exp;
		exp = '{read_data: 32'hffff_ffff, reg_pc: b.reg_pc, alu_out: b.alu_out,
			wb_sel: b.wb_sel};
		if (b.op inside {LB, LH, LW, LBU, LHU})
			exp.read_data = model_load(b.alu_out, b.op);
		if (b.op inside {SB, SH, SW})
			model_store(b.alu_out, b.rs2_data, b.op);
		ex_in = b;
		@(negedge clk);
		check_flag(next_flg, b.op == MEM_X, "next_flg in wait state");
		if (b.op != MEM_X) begin
			do begin
				@(posedge clk);
				@(negedge clk);
			end while (!next_flg);
		end
		@(posedge clk);
		#2;
		ex_in = '0;  // idle alu bundle.
		check_wb(wb_out, exp, "wb_out");
	endtask

	task automatic run_fetch(input logic [31:0] pc);
		logic [31:0] exp;
		exp = model_load({pc[31:2], 2'b00}, LW);
		fetch_start = 1'b1;
		fetch_pc    = pc;
		@(posedge clk);
		#2;
		fetch_start = 1'b0;
		@(negedge clk);
		check_flag(fetch_busy, 1'b1, "fetch_busy after start");
		while (!instr_valid)
			@(negedge clk);
		check_flag(fetch_busy, 1'b0, "fetch_busy with instr_valid");
		check_instr(instr, exp, "instr");
		@(posedge clk);
		#2;
	endtask

	task automatic test_pass_through();
		repeat (3)
			run_access(make_bundle(MEM_X, rand_bits(32), rand_bits(32)));
	endtask

	task automatic test_word_round_trip();
		run_access(make_bundle(SW, 32'h40, rand_bits(32)));
		run_access(make_bundle(LW, 32'h40, 32'h0));
		run_access(make_bundle(SW, 32'h3fc, 32'h8000_0001));
		run_access(make_bundle(LW, 32'h3fc, 32'h0));
	endtask

	task automatic test_partial_stores();
		run_access(make_bundle(SW, 32'h80, 32'h0));
		run_access(make_bundle(SB, 32'h81, 32'h0000_008c));
		run_access(make_bundle(SH, 32'h82, 32'h1234_beef));  // upper half is ignored.
		run_access(make_bundle(SB, 32'h80, 32'h0000_0011));
		run_access(make_bundle(LW, 32'h80, 32'h0));
		run_access(make_bundle(LB, 32'h81, 32'h0));
		run_access(make_bundle(LBU, 32'h81, 32'h0));
		run_access(make_bundle(LB, 32'h80, 32'h0));
		run_access(make_bundle(LH, 32'h82, 32'h0));
		run_access(make_bundle(LHU, 32'h82, 32'h0));
		run_access(make_bundle(LH, 32'h80, 32'h0));
	endtask

	task automatic test_fetch();
		for (int i = 0; i < 3; i++)
			run_access(make_bundle(SW, 32'h100 + 4 * i, rand_bits(32)));
		for (int i = 0; i < 3; i++)
			run_fetch(32'h100 + 4 * i);
		run_fetch(32'h80);
	endtask

	// gap shifts the arbiter phase so both orders show up.
	task automatic test_contention();
		ex_to_mem_t b;
		run_access(make_bundle(SW, 32'hc0, rand_bits(32)));
		for (int gap = 0; gap < 3; gap++) begin
			b = make_bundle(LW, 32'h40 + 32'h40 * gap, 32'h0);
			fork
				run_access(b);
				run_fetch(32'h100 + 4 * gap);
			join
			if (gap > 0) begin
				repeat (gap) @(posedge clk);
				#2;
			end
		end
	endtask

	task automatic test_random_traffic();
		mem_op_e     ops [8] = '{LB, LH, LW, LBU, LHU, SB, SH, SW};
		mem_op_e     op;
		logic [31:0] addr;
		for (int i = 0; i < 32; i++)
			run_access(make_bundle(SW, 32'h200 + 4 * i, rand_bits(32)));
		for (int i = 0; i < 40; i++) begin
			op   = ops[rand_bits(3)];
			addr = 32'h200 + (rand_bits(5) << 2);
			if (op_bytes(op) == 1)
				addr = addr + rand_bits(2);
			else if (op_bytes(op) == 2)
				addr = addr + (rand_bits(1) << 1);
			run_access(make_bundle(op, addr, rand_bits(32)));
		end
	endtask

	initial begin
		rst         = 1'b1;
		ex_in       = '0;
		fetch_start = 1'b0;
		fetch_pc    = '0;
		lfsr        = 32'h3e8b_30a9;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		test_pass_through();
		test_word_round_trip();
		test_partial_stores();
		test_fetch();
		test_contention();
		test_random_traffic();
		if (DUT.u_mem_arbiter.u_arb_asserts.fail_count == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			fail_now("concurrent assertions on the arbiter reported failures");
		end
	end

	initial begin
		#(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
		fail_now("watchdog timeout: the tests did not finish in the allowed time");
	end

endmodule

//--- mem_subsystem.f
common/mem_pkg.sv
source/data_ram.sv
source/mem_arbiter.sv
source/fetch_unit.sv
memory_stage/memory_stage.sv
source/mem_subsystem.sv
bench/mem_subsystem_asserts.sv
bench/mem_subsystem_tb.sv
